//--- Bender.yml
package:
  name: lc3b_core

sources:
  - design/lc3b_types.sv
  - design/control_rom.sv
  - design/fetch_stage.sv
  - design/decode_stage.sv
  - design/execute_stage.sv
  - design/mem_wb_stage.sv
  - design/lc3b_core.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/lc3b_core_tb.sv

//--- design/control_rom.sv
`timescale 1ns/1ns

module control_rom
    import lc3b_types::*;
(
    input  lc3b_opcode       opcode,
    input  logic             imm_enable,
    input  logic             is_nop,
    output lc3b_control_word ctrl
);

    always_comb begin
        // defaults, an instruction with no effect.
        ctrl.opcode = opcode;
        ctrl.load_pc = 1'b0;
        ctrl.load_regfile = 1'b0;
        ctrl.load_cc = 1'b0;
        ctrl.load_mar = 1'b0;
        ctrl.load_mdr = 1'b0;
        ctrl.storemux_sel = 1'b0;
        ctrl.brmux_sel = 1'b0;
        ctrl.alumux_sel = 2'b00;
        ctrl.regfilemux_sel = 2'b00;
        ctrl.aluop = alu_add;
        ctrl.mem_read = 1'b0;
        ctrl.mem_write = 1'b0;
        ctrl.mem_byte_enable = 2'b11;   // word accesses only.

        case (opcode)
            op_add: begin
                ctrl.aluop = alu_add;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
                if (imm_enable) begin
                    ctrl.alumux_sel = 2'b11;   // dr <= a + sext(imm5).
                end
            end
            op_and: begin
                ctrl.aluop = alu_and;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
                if (imm_enable) begin
                    ctrl.alumux_sel = 2'b11;   // dr <= a & sext(imm5).
                end
            end
            op_not: begin
                ctrl.aluop = alu_not;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end
            op_ldr: begin
                // address is base + (sext(offset6) << 1).
                ctrl.aluop = alu_add;
                ctrl.alumux_sel = 2'b01;
                ctrl.load_mar = 1'b1;
                ctrl.mem_read = 1'b1;
                // loaded word goes to dr and sets cc.
                ctrl.regfilemux_sel = 2'b01;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end
            op_str: begin
                ctrl.aluop = alu_add;
                ctrl.alumux_sel = 2'b01;
                ctrl.load_mar = 1'b1;
                ctrl.storemux_sel = 1'b1;   // sr rides on read port b.
                ctrl.load_mdr = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            op_br: begin
                if (!is_nop) begin
                    ctrl.brmux_sel = 1'b1;
                    ctrl.load_pc = 1'b1;
                end
            end
            default: begin
                ctrl = '0;   // unsupported opcode retires with no effect.
            end
        endcase
    end

endmodule : control_rom

//--- design/decode_stage.sv
`timescale 1ns/1ns

module decode_stage
    import lc3b_types::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             branch_taken,
    input  lc3b_word         if_instr,
    input  lc3b_word         if_pc,
    input  logic             if_valid,
    input  logic             wb_enable,
    input  lc3b_reg          wb_dest,
    input  lc3b_word         wb_data,
    output lc3b_control_word id_ctrl,
    output logic             id_valid,
    output lc3b_word         id_pc,
    output lc3b_word         id_a,
    output lc3b_word         id_b,
    output lc3b_word         id_sr,
    output lc3b_reg          id_dest,
    output lc3b_word         id_offset,
    output lc3b_nzp          id_nzp
);

    lc3b_opcode       opcode;
    logic             is_nop;
    logic             imm_enable;
    lc3b_control_word ctrl;
    lc3b_reg          sr1;
    lc3b_reg          sr2;
    lc3b_word         rd_a;
    lc3b_word         rd_b;
    lc3b_word         offset;
    lc3b_word         regs [8];

    assign opcode = lc3b_opcode'(if_instr[15:12]);
    assign is_nop = (opcode == op_br) && (if_instr[11:9] == 3'b000);   // br with no cond.
    assign imm_enable = if_instr[5];

    control_rom control_rom_i (
        .opcode     (opcode),
        .imm_enable (imm_enable),
        .is_nop     (is_nop),
        .ctrl       (ctrl)
    );

    assign sr1 = if_instr[8:6];
    assign sr2 = ctrl.storemux_sel ? if_instr[11:9] : if_instr[2:0];

    // write-through, a read sees the value written on this edge.
    assign rd_a = (wb_enable && wb_dest == sr1) ? wb_data : regs[sr1];
    assign rd_b = (wb_enable && wb_dest == sr2) ? wb_data : regs[sr2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_enable) begin
            regs[wb_dest] <= wb_data;
        end
    end

    always_comb begin
        case (opcode)
            op_add, op_and: offset = {{11{if_instr[4]}}, if_instr[4:0]};   // imm5.
            op_ldr, op_str: offset = {{10{if_instr[5]}}, if_instr[5:0]};   // offset6.
            op_br:          offset = {{7{if_instr[8]}}, if_instr[8:0]};    // offset9.
            default:        offset = '0;
        endcase
    end

    // ID/EX register, squashed when the branch in execute is taken.
    always_ff @(posedge clk) begin
        if (reset) begin
            id_valid <= 1'b0;
            id_ctrl <= '0;
        end else begin
            id_valid <= if_valid && !branch_taken;
            id_ctrl <= ctrl;
        end
    end

    always_ff @(posedge clk) begin
        id_pc <= if_pc;
        id_a <= rd_a;
        id_b <= rd_b;
        id_sr <= ctrl.storemux_sel ? rd_b : '0;   // store data only for STR.
        id_dest <= if_instr[11:9];
        id_offset <= offset;
        id_nzp <= if_instr[11:9];
    end

endmodule : decode_stage

//--- design/execute_stage.sv
`timescale 1ns/1ns

module execute_stage
    import lc3b_types::*;
(
    input  logic             clk,
    input  logic             reset,
    input  lc3b_control_word id_ctrl,
    input  logic             id_valid,
    input  lc3b_word         id_pc,
    input  lc3b_word         id_a,
    input  lc3b_word         id_b,
    input  lc3b_word         id_sr,
    input  lc3b_reg          id_dest,
    input  lc3b_word         id_offset,
    input  lc3b_nzp          id_nzp,
    input  lc3b_nzp          cc,
    output logic             branch_taken,
    output lc3b_word         branch_target,
    output lc3b_control_word ex_ctrl,
    output logic             ex_valid,
    output lc3b_word         ex_result,
    output lc3b_word         ex_address,
    output lc3b_word         ex_store_data,
    output lc3b_reg          ex_dest
);

    lc3b_word alu_b;
    lc3b_word alu_out;
    lc3b_word offset_x2;    // word offset turned into a byte offset.
    lc3b_word br_sum;

    assign offset_x2 = {id_offset[14:0], 1'b0};

    always_comb begin
        case (id_ctrl.alumux_sel)
            2'b01:   alu_b = offset_x2;
            2'b11:   alu_b = id_offset;
            default: alu_b = id_b;
        endcase
    end

    always_comb begin
        case (id_ctrl.aluop)
            alu_add: alu_out = id_a + alu_b;
            alu_and: alu_out = id_a & alu_b;
            alu_not: alu_out = ~id_a;
            default: alu_out = alu_b;   // pass.
        endcase
    end

    // id_pc already points past the branch.
    assign br_sum = id_pc + offset_x2;
    assign branch_target = id_ctrl.brmux_sel ? br_sum : id_pc;

    // cc is the value left by the last retired producer.
    assign branch_taken = id_valid && id_ctrl.load_pc
                          && (id_ctrl.opcode == op_br) && ((cc & id_nzp) != 3'b000);

    // EX/MEM register.
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
            ex_ctrl <= '0;
        end else begin
            ex_valid <= id_valid;
            ex_ctrl <= id_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        ex_result <= alu_out;
        ex_address <= alu_out;   // LDR and STR reuse the adder.
        ex_store_data <= id_sr;
        ex_dest <= id_dest;
    end

endmodule : execute_stage

//--- design/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage
    import lc3b_types::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     branch_taken,
    input  lc3b_word branch_target,
    input  lc3b_word imem_rdata,
    output lc3b_word imem_address,
    output lc3b_word if_instr,
    output lc3b_word if_pc,
    output logic     if_valid
);

    lc3b_word pc;
    lc3b_word pc_next;   // address of the instruction after this one.

    assign imem_address = pc;
    assign pc_next = pc + pc_step;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= pc_reset_value;
            if_valid <= 1'b0;
        end else if (branch_taken) begin
            pc <= branch_target;
            if_valid <= 1'b0;   // word fetched now is on the wrong path.
        end else begin
            pc <= pc_next;
            if_valid <= 1'b1;
        end
    end

    // IF/ID payload.
    always_ff @(posedge clk) begin
        if_instr <= imem_rdata;
        if_pc <= pc_next;
    end

endmodule : fetch_stage

//--- design/lc3b_core.sv
`timescale 1ns/1ns

module lc3b_core
    import lc3b_types::*;
(
    input  logic       clk,
    input  logic       reset,
    output lc3b_word   imem_address,
    input  lc3b_word   imem_rdata,
    output lc3b_word   dmem_address,
    output lc3b_word   dmem_wdata,
    input  lc3b_word   dmem_rdata,
    output logic       dmem_read,
    output logic       dmem_write,
    output logic [1:0] dmem_byte_enable
);

    // fetch to decode.
    lc3b_word if_instr;
    lc3b_word if_pc;
    logic     if_valid;

    // decode to execute.
    lc3b_control_word id_ctrl;
    logic             id_valid;
    lc3b_word         id_pc;
    lc3b_word         id_a;
    lc3b_word         id_b;
    lc3b_word         id_sr;
    lc3b_reg          id_dest;
    lc3b_word         id_offset;
    lc3b_nzp          id_nzp;

    // execute to memory/writeback.
    lc3b_control_word ex_ctrl;
    logic             ex_valid;
    lc3b_word         ex_result;
    lc3b_word         ex_address;
    lc3b_word         ex_store_data;
    lc3b_reg          ex_dest;

    // feedback paths.
    logic     branch_taken;
    lc3b_word branch_target;
    logic     wb_enable;
    lc3b_reg  wb_dest;
    lc3b_word wb_data;
    lc3b_nzp  cc;

    fetch_stage fetch_stage_i (
        .clk (clk), .reset (reset),
        .branch_taken (branch_taken), .branch_target (branch_target),
        .imem_rdata (imem_rdata), .imem_address (imem_address),
        .if_instr (if_instr), .if_pc (if_pc), .if_valid (if_valid)
    );

    decode_stage decode_stage_i (
        .clk (clk), .reset (reset), .branch_taken (branch_taken),
        .if_instr (if_instr), .if_pc (if_pc), .if_valid (if_valid),
        .wb_enable (wb_enable), .wb_dest (wb_dest), .wb_data (wb_data),
        .id_ctrl (id_ctrl), .id_valid (id_valid), .id_pc (id_pc),
        .id_a (id_a), .id_b (id_b), .id_sr (id_sr), .id_dest (id_dest),
        .id_offset (id_offset), .id_nzp (id_nzp)
    );

    execute_stage execute_stage_i (
        .clk (clk), .reset (reset),
        .id_ctrl (id_ctrl), .id_valid (id_valid), .id_pc (id_pc),
        .id_a (id_a), .id_b (id_b), .id_sr (id_sr), .id_dest (id_dest),
        .id_offset (id_offset), .id_nzp (id_nzp), .cc (cc),
        .branch_taken (branch_taken), .branch_target (branch_target),
        .ex_ctrl (ex_ctrl), .ex_valid (ex_valid), .ex_result (ex_result),
        .ex_address (ex_address), .ex_store_data (ex_store_data), .ex_dest (ex_dest)
    );

    mem_wb_stage mem_wb_stage_i (
        .clk (clk), .reset (reset),
        .ex_ctrl (ex_ctrl), .ex_valid (ex_valid), .ex_result (ex_result),
        .ex_address (ex_address), .ex_store_data (ex_store_data), .ex_dest (ex_dest),
        .dmem_rdata (dmem_rdata), .dmem_address (dmem_address),
        .dmem_wdata (dmem_wdata), .dmem_read (dmem_read), .dmem_write (dmem_write),
        .dmem_byte_enable (dmem_byte_enable),
        .wb_enable (wb_enable), .wb_dest (wb_dest), .wb_data (wb_data), .cc (cc)
    );

endmodule : lc3b_core

//--- design/lc3b_types.sv
package lc3b_types;

    typedef logic [15:0] lc3b_word;   // data and byte address.
    typedef logic [2:0]  lc3b_reg;    // register index.
    typedef logic [2:0]  lc3b_nzp;    // condition code or BR condition field.

    // ISA opcode encodings, IR[15:12].
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } lc3b_aluop;

    // control word, follows the instruction from decode to writeback.
    typedef struct packed {
        lc3b_opcode opcode;
        logic       load_pc;          // taken-branch candidate.
        logic       load_regfile;
        logic       load_cc;
        logic       load_mar;         // address in EX/MEM is valid.
        logic       load_mdr;         // store data in EX/MEM is valid.
        logic       storemux_sel;     // port b reads IR[11:9].
        logic       brmux_sel;        // target from the offset adder.
        logic [1:0] alumux_sel;       // 00 reg b, 01 offset6 << 1, 11 imm5.
        logic [1:0] regfilemux_sel;   // 00 alu result, 01 memory data.
        lc3b_aluop  aluop;
        logic       mem_read;
        logic       mem_write;
        logic [1:0] mem_byte_enable;
    } lc3b_control_word;

    localparam lc3b_word pc_reset_value = 16'h0000;
    localparam lc3b_word pc_step = 16'd2;   // byte addressed, two bytes per word.

endpackage : lc3b_types

//--- design/mem_wb_stage.sv
`timescale 1ns/1ns

module mem_wb_stage
    import lc3b_types::*;
(
    input  logic             clk,
    input  logic             reset,
    input  lc3b_control_word ex_ctrl,
    input  logic             ex_valid,
    input  lc3b_word         ex_result,
    input  lc3b_word         ex_address,
    input  lc3b_word         ex_store_data,
    input  lc3b_reg          ex_dest,
    input  lc3b_word         dmem_rdata,
    output lc3b_word         dmem_address,
    output lc3b_word         dmem_wdata,
    output logic             dmem_read,
    output logic             dmem_write,
    output logic [1:0]       dmem_byte_enable,
    output logic             wb_enable,
    output lc3b_reg          wb_dest,
    output lc3b_word         wb_data,
    output lc3b_nzp          cc
);

    // memory strobes are single-cycle levels.
    assign dmem_read = ex_valid && ex_ctrl.mem_read;
    assign dmem_write = ex_valid && ex_ctrl.mem_write;
    assign dmem_address = (ex_valid && ex_ctrl.load_mar) ? ex_address : '0;
    assign dmem_wdata = ex_ctrl.load_mdr ? ex_store_data : '0;
    assign dmem_byte_enable = ex_ctrl.mem_byte_enable;

    assign wb_data = (ex_ctrl.regfilemux_sel == 2'b01) ? dmem_rdata : ex_result;
    assign wb_enable = ex_valid && ex_ctrl.load_regfile;
    assign wb_dest = ex_dest;

    always_ff @(posedge clk) begin
        if (reset) begin
            cc <= 3'b010;
        end else if (ex_valid && ex_ctrl.load_cc) begin
            if (wb_data[15])
                cc <= 3'b100;   // negative.
            else if (wb_data == '0)
                cc <= 3'b010;
            else
                cc <= 3'b001;
        end
    end

endmodule : mem_wb_stage

//--- filelist.f
design/lc3b_types.sv
design/control_rom.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/lc3b_core.sv
sim/tb_clock.sv
sim/lc3b_core_tb.sv

//--- sim/lc3b_core_tb.sv
`timescale 1ns/1ns

module lc3b_core_tb
    import lc3b_types::*;
();

    localparam int prog_len = 60;
    localparam int store_count = 18;
    localparam int load_total = 3;
    localparam int store_timeout = 50;   // cycles allowed between two stores.
    localparam int quiet_cycles = 40;

    logic       clk;
    logic       reset;
    lc3b_word   imem_address;
    lc3b_word   imem_rdata;
    lc3b_word   dmem_address;
    lc3b_word   dmem_wdata;
    lc3b_word   dmem_rdata;
    logic       dmem_read;
    logic       dmem_write;
    logic [1:0] dmem_byte_enable;

    lc3b_word    prog [prog_len];
    logic [31:0] expected [store_count];   // {address, data} in store order.
    lc3b_word    dmem [64];
    int          loads_seen;               // dmem_read pulses so far.

    tb_clock tb_clock_i (
        .clk (clk)
    );

    lc3b_core lc3b_core_i (
        .clk              (clk),
        .reset            (reset),
        .imem_address     (imem_address),
        .imem_rdata       (imem_rdata),
        .dmem_address     (dmem_address),
        .dmem_wdata       (dmem_wdata),
        .dmem_rdata       (dmem_rdata),
        .dmem_read        (dmem_read),
        .dmem_write       (dmem_write),
        .dmem_byte_enable (dmem_byte_enable)
    );

    function automatic lc3b_word fetch_word(input lc3b_word address);
        int idx;
        idx = int'(address >> 1);
        if (idx < prog_len)
            return prog[idx];
        else
            return 16'h0000;   // nop past the end of the program.
    endfunction

    task automatic check_value(input string what, input lc3b_word got, input lc3b_word want);
        if (got !== want) begin
            $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, want);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wait_for_store(input int row);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!dmem_write && cycles < store_timeout);
        if (!dmem_write) begin
            $display("store %0d of the expected list never came within %0d cycles",
                     row, store_timeout);
            $display("TESTS FAILED");
            $fatal(1, "store timeout");
        end
    endtask

    task automatic watch_for_extra_stores();
        for (int i = 0; i < quiet_cycles; i++) begin
            @(negedge clk);
            if (dmem_write) begin
                $display("an extra store to address %h with data %h came after the last one",
                         dmem_address, dmem_wdata);
                $display("TESTS FAILED");
                $fatal(1, "extra store");
            end
        end
    endtask

    // memories answer on the falling edge, once pc and ex/mem have settled.
    initial begin
        imem_rdata = '0;
        dmem_rdata = '0;
        loads_seen = 0;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = {2'b10, i[5:0], 2'b01, ~i[5:0]};
        end
        dmem[31] = 16'h0060;   // byte 0x3e, base for the next loads.
        dmem[44] = 16'hBEEF;   // byte 0x58.
        dmem[51] = 16'h1234;   // byte 0x66.
        forever begin
            @(negedge clk);
            if (dmem_write) begin
                dmem[dmem_address[6:1]] <= dmem_wdata;
            end
            if (dmem_read) begin
                loads_seen++;
            end
            imem_rdata <= fetch_word(imem_address);
            dmem_rdata <= dmem[dmem_address[6:1]];
        end
    end

    initial begin
        reset = 1'b1;
        prog = '{
            // alu forms, each result stored at 0x00..0x08.
            16'h1227, 16'h0000, 16'h143D, 16'h0000, 16'h1642, 16'h0000, 16'h7600,   // w0-6
            16'h5842, 16'h0000, 16'h7801, 16'h58B8, 16'h0000, 16'h7802,   // w7-12
            16'h9AFF, 16'h0000, 16'h7A03, 16'h1D41, 16'h0000, 16'h7C04,   // w13-18
            // ldr at positive and negative offsets.
            16'h6A1F, 16'h0000, 16'h637C, 16'h6543, 16'h0000, 16'h7205, 16'h7406,   // w19-25
            // r3 read one slot and two slots after its producer.
            16'h16E1, 16'h7607, 16'h7608,   // w26-28
            // taken branches on n, z and p. the 0x781e stores sit on the wrong path.
            16'h98FF, 16'h0000, 16'h0803, 16'h781E, 16'h781E, 16'h781E, 16'h7809,   // w29-35
            16'h5DA0, 16'h0000, 16'h0402, 16'h781E, 16'h781E, 16'h7C0A,   // w36-41
            16'h1DA9, 16'h0000, 16'h0202, 16'h781E, 16'h781E, 16'h7C0B,   // w42-47
            // brnz not taken, nop with an offset, undefined opcode 1101.
            16'h0C02, 16'h7C0C, 16'h0003, 16'h7C0D, 16'h720E,   // w48-52
            16'hDDB7, 16'h0000, 16'h7C0F, 16'h0C02, 16'h7C10, 16'h7411,   // w53-58
            16'h0FFF   // w59 brnzp to itself.
        };
        expected = '{
            32'h0000_0004, 32'h0002_0005, 32'h0004_FFF8, 32'h0006_FFFB, 32'h0008_0002,
            32'h000A_BEEF, 32'h000C_1234, 32'h000E_0004, 32'h0010_0005, 32'h0012_FFFA,
            32'h0014_0000, 32'h0016_0009, 32'h0018_0009, 32'h001A_0009, 32'h001C_BEEF,
            32'h001E_0009, 32'h0020_0009, 32'h0022_1234
        };
        repeat (16) @(negedge clk);
        reset = 1'b0;
        for (int k = 0; k < store_count; k++) begin
            wait_for_store(k);
            check_value($sformatf("store %0d address", k), dmem_address, expected[k][31:16]);
            check_value($sformatf("store %0d data", k), dmem_wdata, expected[k][15:0]);
            check_value($sformatf("store %0d byte enable", k),
                        {14'b0, dmem_byte_enable}, 16'h0003);
        end
        watch_for_extra_stores();   // the core now spins on the last branch.
        check_value("number of loads", 16'(loads_seen), 16'(load_total));
        $display("TESTS PASSED");
        $finish;
    end

endmodule : lc3b_core_tb

//--- sim/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period.
    end

endmodule : tb_clock
